// File: rtl/ts_cfg.svh
`ifndef TS_CFG_SVH
`define TS_CFG_SVH

// sprite file size in 16-bit words
// three words per sprite record
`define TS_SFILE_WORDS 256

// record base where the sprite walk stops
// 85 records fit below it
`define TS_SPR_LAST 255

// one prefetched tilemap row
// 64 descriptors cover 512 pixels of 8-pixel tiles
`define TS_TMB_WORDS 64

`endif

// File: rtl/ts_desc_pkg.sv
`default_nettype none

package ts_desc_pkg;

	// tilemap word as it comes from DRAM
	typedef struct packed {
		logic yflip;
		logic xflip;
		logic [1:0] pal;
		logic [11:0] tnum;
	} tile_desc_t;

	// sprite record word 0, vertical placement and flags
	typedef struct packed {
		logic yflip;
		logic leap;
		logic act;
		logic spare;
		logic [2:0] ysz;
		logic [8:0] y;
	} spr_r0_t;

	// sprite record word 1, horizontal placement
	typedef struct packed {
		logic xflip;
		logic [2:0] spare;
		logic [2:0] xs;
		logic [8:0] x;
	} spr_r1_t;

	// sprite record word 2
	typedef struct packed {
		logic [3:0] pal;
		logic [11:0] tnum;
	} spr_r2_t;

	// one renderer task, 40 bits
	typedef struct packed {
		logic [7:0] page;
		logic [8:0] line;
		logic [5:0] addr;
		logic [8:0] x;
		logic [2:0] xs;
		logic xf;
		logic [3:0] pal;
	} ts_task_t;

endpackage

`default_nettype wire

// File: rtl/ts_seq_pkg.sv
`default_nettype none

package ts_seq_pkg;

	// one-hot, bit order is the back-to-front walk
	// none while the line is idle
	typedef enum logic [3:0] {
		LY_NONE = 4'b0000,
		LY_TM = 4'b0001,
		LY_S0 = 4'b0010,
		LY_T = 4'b0100,
		LY_S1 = 4'b1000
	} layer_e;

	// sprite walk, PRE states wait out the RAM read
	typedef enum logic [2:0] {
		SP_IDLE,
		SP_R0_PRE,
		SP_R0,
		SP_R1_PRE,
		SP_R1,
		SP_R2
	} spr_state_e;

	// tile stage
	typedef enum logic [1:0] {
		TL_FETCH,
		TL_PRE,
		TL_VALID,
		TL_IDLE
	} tile_state_e;

endpackage

`default_nettype wire

// File: rtl/ts_task_if.sv
`timescale 1ns/1ns
`default_nettype none

interface ts_task_if;
	// task fields, valid with go
	logic go;
	logic [7:0] page;
	logic [8:0] line;
	logic [5:0] addr;
	logic [8:0] x;
	logic [2:0] xs;
	logic xf;
	logic [3:0] pal;
	// go allowed only while high
	logic rdy;

	modport src (output go, page, line, addr, x, xs, xf, pal, input rdy);
	modport mux (input go, page, line, addr, x, xs, xf, pal, output rdy);
	// stand-in for a scan stage on a block bench
	modport drv (output go, page, line, addr, x, xs, xf, pal, input rdy);
	// passive observer
	modport mon (input go, page, line, addr, x, xs, xf, pal, rdy);
endinterface

`default_nettype wire

// File: rtl/ts_dpram.sv
`timescale 1ns/1ns
`default_nettype none

module ts_dpram #(
	parameter int DEPTH = 256,
	parameter type T = logic [15:0]
) (
	input wire clk,
	input wire we,
	input wire [$clog2(DEPTH)-1:0] waddr,
	input wire T wdata,
	input wire [$clog2(DEPTH)-1:0] raddr,
	output T rdata
);
	// payload storage
	T mem [DEPTH];

	// registered read returns the old word on a same-address write
	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr];
	end
endmodule

`default_nettype wire

// File: rtl/ts_tile_scan.sv
`timescale 1ns/1ns
`default_nettype none

`include "ts_cfg.svh"

module ts_tile_scan (
	input wire clk,
	input wire rst,
	input wire start,
	input wire [8:0] line,
	input wire ts_seq_pkg::layer_e layer,
	input wire [7:0] tgpage,
	input wire [7:0] tmpage,
	input wire [5:0] num_tiles,
	input wire [8:0] tx_offs,
	input wire [8:0] ty_offs,
	input wire [1:0] t_palsel,
	input wire dram_next,
	input wire [15:0] dram_rdata,
	output logic dram_req,
	output logic [20:0] dram_addr,
	output logic layer_end,
	ts_task_if.src task_o
);
	import ts_seq_pkg::*;
	import ts_desc_pkg::*;

	tile_state_e state;
	logic [5:0] tx;
	logic [5:0] tx_nxt;
	logic [8:0] t_line;
	logic [5:0] tm_col;
	logic tm_next;
	logic tm_last;
	logic t_valid;
	logic t_skip;
	logic t_go;
	logic t_last;
	tile_desc_t desc;

	// scrolled line, top bits pick the row, low bits the line in the tile
	assign t_line = line + ty_offs;
	// column wraps mod 64 by width
	assign tm_col = tx + tx_offs[8:3];

	// fetch only while TM is active and words remain
	assign dram_req = (layer == LY_TM) && (state == TL_FETCH);
	// page, row, plane bit (plane 0 only), column
	assign dram_addr = {tmpage, t_line[8:3], 1'b0, tm_col};
	assign tm_next = dram_req && dram_next;
	assign tm_last = tm_next && (tx == num_tiles);

	// descriptor of entry tx sits on the RAM output in VALID
	assign t_valid = (state == TL_VALID);
	assign t_skip = t_valid && (desc.tnum == 12'd0);
	assign t_go = t_valid && (desc.tnum != 12'd0) && task_o.rdy;
	assign t_last = (t_skip || t_go) && (tx == num_tiles);
	assign layer_end = tm_last || t_last;

	// read address runs one step ahead
	// so a zero tile costs one cycle
	always_comb
	begin
		if (t_skip || t_go)
			tx_nxt = tx + 6'd1;
		else
			tx_nxt = tx;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= TL_IDLE;
			tx <= '0;
		end
		else if (start)
		begin
			state <= TL_FETCH;
			tx <= '0;
		end
		else
		begin
			case (state)
				TL_FETCH:
					if (tm_last)
					begin
						state <= TL_PRE;
						tx <= '0;
					end
					else if (tm_next)
						tx <= tx + 6'd1;
				// entry 0 read is issued here, hold until T
				TL_PRE:
					if (layer == LY_T)
						state <= TL_VALID;
				TL_VALID:
				begin
					tx <= tx_nxt;
					if (t_last)
						state <= TL_IDLE;
				end
				default:
					state <= TL_IDLE;
			endcase
		end
	end

	// task from the current descriptor
	assign task_o.go = t_go;
	assign task_o.page = tgpage;
	assign task_o.line = {desc.tnum[11:6], t_line[2:0] ^ {3{desc.yflip}}};
	assign task_o.addr = desc.tnum[5:0];
	// fine scroll shifts every tile left
	assign task_o.x = {tx, 3'b000} - {6'd0, tx_offs[2:0]};
	assign task_o.xs = 3'd0;
	assign task_o.xf = desc.xflip;
	assign task_o.pal = {t_palsel, desc.pal};

	// row buffer, written by tx from DRAM
	ts_dpram #(
		.DEPTH(`TS_TMB_WORDS),
		.T(tile_desc_t)
	) u_tmbuf (
		.clk(clk),
		.we(tm_next),
		.waddr(tx),
		.wdata(tile_desc_t'(dram_rdata)),
		.raddr(tx_nxt),
		.rdata(desc)
	);
endmodule

`default_nettype wire

// File: rtl/ts_sprite_scan.sv
`timescale 1ns/1ns
`default_nettype none

`include "ts_cfg.svh"

module ts_sprite_scan (
	input wire clk,
	input wire rst,
	input wire start,
	input wire [8:0] line,
	input wire ts_seq_pkg::layer_e layer,
	input wire [7:0] sgpage,
	input wire [15:0] sfile_rdata,
	output logic [7:0] sfile_raddr,
	output logic layer_end,
	output logic last,
	ts_task_if.src task_o
);
	import ts_seq_pkg::*;
	import ts_desc_pkg::*;

	spr_state_e state;
	logic [7:0] sreg;
	logic run;
	spr_r0_t r0;
	spr_r1_t r1;
	spr_r2_t r2;
	logic [8:0] s_line;
	logic [5:0] s_ymax;
	logic s_vis;
	logic [5:0] s_off;
	logic s_go;
	logic [5:0] off_r;
	logic leap_r;
	logic [8:0] x_r;
	logic [2:0] xs_r;
	logic xf_r;

	// same RAM word seen through each record format
	assign r0 = spr_r0_t'(sfile_rdata);
	assign r1 = spr_r1_t'(sfile_rdata);
	assign r2 = spr_r2_t'(sfile_rdata);

	// walk stalls outside the sprite layers
	assign run = (layer == LY_S0) || (layer == LY_S1);
	assign sfile_raddr = sreg;

	// line within the sprite, wraps mod 512
	assign s_line = line - r0.y;
	assign s_ymax = {r0.ysz, 3'b111};
	assign s_vis = r0.act && (s_line <= {3'b000, s_ymax});
	assign s_off = r0.yflip ? (s_ymax - s_line[5:0]) : s_line[5:0];

	// end of file closes this layer and any later one
	assign last = run && (state == SP_R0_PRE) && (sreg == 8'(`TS_SPR_LAST));
	assign s_go = run && (state == SP_R2) && task_o.rdy;

	// leap closes the layer whether the sprite was shown or not
	assign layer_end = last
		|| (run && (state == SP_R0) && !s_vis && r0.leap)
		|| (s_go && leap_r);

	// sreg is the RAM address, read data lags by one state
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= SP_IDLE;
			sreg <= '0;
		end
		else if (start)
		begin
			state <= SP_R0_PRE;
			sreg <= '0;
		end
		else if (run)
		begin
			case (state)
				SP_R0_PRE:
					if (last)
						state <= SP_IDLE;
					else
						state <= SP_R0;
				SP_R0:
					if (s_vis)
					begin
						state <= SP_R1_PRE;
						sreg <= sreg + 8'd1;
					end
					else
					begin
						// skip the whole record
						state <= SP_R0_PRE;
						sreg <= sreg + 8'd3;
					end
				SP_R1_PRE:
				begin
					// word 2 read goes out while word 1 comes back
					state <= SP_R1;
					sreg <= sreg + 8'd1;
				end
				SP_R1:
					state <= SP_R2;
				SP_R2:
					if (s_go)
					begin
						state <= SP_R0_PRE;
						sreg <= sreg + 8'd1;
					end
				default:
					state <= SP_IDLE;
			endcase
		end
	end

	// word 0 and word 1 fields kept for the issue cycle
	always_ff @(posedge clk)
	begin
		if (state == SP_R0)
		begin
			leap_r <= r0.leap;
			off_r <= s_off;
		end
		if (state == SP_R1)
		begin
			x_r <= r1.x;
			xs_r <= r1.xs;
			xf_r <= r1.xflip;
		end
	end

	// word 2 is live on the RAM output in R2
	assign task_o.go = s_go;
	assign task_o.page = sgpage;
	assign task_o.line = {r2.tnum[11:6], 3'b000} + {3'b000, off_r};
	assign task_o.addr = r2.tnum[5:0];
	assign task_o.x = x_r;
	assign task_o.xs = xs_r;
	assign task_o.xf = xf_r;
	assign task_o.pal = r2.pal;
endmodule

`default_nettype wire

// File: rtl/ts_layer_seq.sv
`timescale 1ns/1ns
`default_nettype none

module ts_layer_seq (
	input wire clk,
	input wire rst,
	input wire start,
	input wire spr_en,
	input wire tile_en,
	input wire tile_end,
	input wire spr_end,
	input wire spr_last,
	input wire tsr_rdy,
	output ts_seq_pkg::layer_e layer,
	output logic busy,
	ts_task_if.mux tile_task,
	ts_task_if.mux spr_task,
	output logic tsr_go,
	output logic [7:0] tsr_page,
	output logic [8:0] tsr_line,
	output logic [5:0] tsr_addr,
	output logic [8:0] tsr_x,
	output logic [2:0] tsr_xs,
	output logic tsr_xf,
	output logic [3:0] tsr_pal
);
	import ts_seq_pkg::*;

	logic [3:0] skip;
	logic [3:0] en_mask;
	logic [3:0] done_mask;
	logic [3:0] rest;
	logic tile_lyr;
	logic tile_sel;
	logic spr_sel;
	logic lyr_end;

	// lowest pending bit is the next layer back to front
	function automatic logic [3:0] first_of(input logic [3:0] m);
		logic [3:0] r;
		r = m & (~m + 4'd1);
		return r;
	endfunction

	// bit order S1, T, S0, TM
	assign en_mask = {spr_en, tile_en, spr_en, tile_en};

	assign tile_lyr = (layer == LY_TM) || (layer == LY_T);
	assign tile_sel = (layer == LY_T);
	assign spr_sel = (layer == LY_S0) || (layer == LY_S1);
	assign lyr_end = (tile_lyr && tile_end) || (spr_sel && spr_end);

	// sprite file exhausted means S1 has nothing left
	assign done_mask = layer | {spr_last, 3'b000};
	assign rest = ~(skip | done_mask);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			skip <= '1;
			layer <= LY_NONE;
			busy <= 1'b0;
		end
		else if (start)
		begin
			skip <= ~en_mask;
			layer <= layer_e'(first_of(en_mask));
			busy <= |en_mask;
		end
		else if (lyr_end)
		begin
			skip <= skip | done_mask;
			layer <= layer_e'(first_of(rest));
			busy <= |rest;
		end
	end

	// only the active stage sees the renderer ready
	assign tile_task.rdy = tsr_rdy && tile_sel;
	assign spr_task.rdy = tsr_rdy && spr_sel;

	assign tsr_go = tile_task.go || spr_task.go;
	assign tsr_page = spr_sel ? spr_task.page : tile_task.page;
	assign tsr_line = spr_sel ? spr_task.line : tile_task.line;
	assign tsr_addr = spr_sel ? spr_task.addr : tile_task.addr;
	assign tsr_x = spr_sel ? spr_task.x : tile_task.x;
	assign tsr_xs = spr_sel ? spr_task.xs : tile_task.xs;
	assign tsr_xf = spr_sel ? spr_task.xf : tile_task.xf;
	assign tsr_pal = spr_sel ? spr_task.pal : tile_task.pal;
endmodule

`default_nettype wire

// File: rtl/video_ts.sv
`timescale 1ns/1ns
`default_nettype none

`include "ts_cfg.svh"

module video_ts (
	input wire clk,
	input wire rst,
	input wire start,
	input wire [8:0] line,
	input wire spr_en,
	input wire tile_en,
	input wire [7:0] tgpage,
	input wire [7:0] sgpage,
	input wire [7:0] tmpage,
	input wire [5:0] num_tiles,
	input wire [8:0] tx_offs,
	input wire [8:0] ty_offs,
	input wire [1:0] t_palsel,
	input wire [7:0] sfile_addr,
	input wire [15:0] sfile_data,
	input wire sfile_we,
	input wire tsr_rdy,
	input wire dram_next,
	input wire [15:0] dram_rdata,
	output logic tsr_go,
	output logic [7:0] tsr_page,
	output logic [8:0] tsr_line,
	output logic [5:0] tsr_addr,
	output logic [8:0] tsr_x,
	output logic [2:0] tsr_xs,
	output logic tsr_xf,
	output logic [3:0] tsr_pal,
	output logic [20:0] dram_addr,
	output logic dram_req,
	output logic busy
);
	import ts_seq_pkg::*;

	layer_e layer;
	logic tile_end;
	logic spr_end;
	logic spr_last;
	logic [7:0] sfile_raddr;
	logic [15:0] sfile_rdata;

	// one task channel per scan stage
	ts_task_if tile_task ();
	ts_task_if spr_task ();

	ts_layer_seq u_layer_seq (
		.clk(clk),
		.rst(rst),
		.start(start),
		.spr_en(spr_en),
		.tile_en(tile_en),
		.tile_end(tile_end),
		.spr_end(spr_end),
		.spr_last(spr_last),
		.tsr_rdy(tsr_rdy),
		.layer(layer),
		.busy(busy),
		.tile_task(tile_task.mux),
		.spr_task(spr_task.mux),
		.tsr_go(tsr_go),
		.tsr_page(tsr_page),
		.tsr_line(tsr_line),
		.tsr_addr(tsr_addr),
		.tsr_x(tsr_x),
		.tsr_xs(tsr_xs),
		.tsr_xf(tsr_xf),
		.tsr_pal(tsr_pal)
	);

	// TM prefetch and T plane
	ts_tile_scan u_tile_scan (
		.clk(clk),
		.rst(rst),
		.start(start),
		.line(line),
		.layer(layer),
		.tgpage(tgpage),
		.tmpage(tmpage),
		.num_tiles(num_tiles),
		.tx_offs(tx_offs),
		.ty_offs(ty_offs),
		.t_palsel(t_palsel),
		.dram_next(dram_next),
		.dram_rdata(dram_rdata),
		.dram_req(dram_req),
		.dram_addr(dram_addr),
		.layer_end(tile_end),
		.task_o(tile_task.src)
	);

	// S0 and S1
	ts_sprite_scan u_sprite_scan (
		.clk(clk),
		.rst(rst),
		.start(start),
		.line(line),
		.layer(layer),
		.sgpage(sgpage),
		.sfile_rdata(sfile_rdata),
		.sfile_raddr(sfile_raddr),
		.layer_end(spr_end),
		.last(spr_last),
		.task_o(spr_task.src)
	);

	// sprite file, loaded from outside between lines
	ts_dpram #(
		.DEPTH(`TS_SFILE_WORDS),
		.T(logic [15:0])
	) u_sfile (
		.clk(clk),
		.we(sfile_we),
		.waddr(sfile_addr),
		.wdata(sfile_data),
		.raddr(sfile_raddr),
		.rdata(sfile_rdata)
	);
endmodule

`default_nettype wire

// File: verif/tb_video_ts.sv
`timescale 1ns/1ns
`default_nettype none

`include "ts_cfg.svh"

module tb_video_ts;
	import ts_desc_pkg::*;

	// six lines of at most 2048 cycles plus two sprite file loads and reset
	localparam int LINE_CYCLES = 2048;
	localparam int LIMIT = 6 * LINE_CYCLES + 2 * 260 + 20;

	logic clk = 1'b0;
	logic rst;
	logic start;
	logic [8:0] line;
	logic spr_en;
	logic tile_en;
	logic [7:0] tgpage;
	logic [7:0] sgpage;
	logic [7:0] tmpage;
	logic [5:0] num_tiles;
	logic [8:0] tx_offs;
	logic [8:0] ty_offs;
	logic [1:0] t_palsel;
	logic [7:0] sfile_addr;
	logic [15:0] sfile_data;
	logic sfile_we;
	logic tsr_rdy;
	logic dram_next;
	logic [15:0] dram_rdata;
	logic tsr_go;
	logic [7:0] tsr_page;
	logic [8:0] tsr_line;
	logic [5:0] tsr_addr;
	logic [8:0] tsr_x;
	logic [2:0] tsr_xs;
	logic tsr_xf;
	logic [3:0] tsr_pal;
	logic [20:0] dram_addr;
	logic dram_req;
	logic busy;

	// models and bookkeeping
	logic [15:0] lfsr = 16'd23766;
	logic [15:0] tmap [4096];
	logic [15:0] smem [`TS_SFILE_WORDS];
	ts_task_t exp_task[$];
	ts_task_t got_task[$];
	ts_task_t prev_task[$];
	logic [20:0] exp_addr[$];
	logic [20:0] got_addr[$];
	logic rdy_rand = 1'b0;
	logic dram_rand = 1'b0;
	logic req_seen;
	logic busy_q = 1'b0;
	int gap = 0;
	int cycles = 0;
	int last_go_cyc;
	int fall_cyc;

	video_ts u_video_ts (
		.clk(clk), .rst(rst), .start(start), .line(line),
		.spr_en(spr_en), .tile_en(tile_en),
		.tgpage(tgpage), .sgpage(sgpage), .tmpage(tmpage),
		.num_tiles(num_tiles), .tx_offs(tx_offs), .ty_offs(ty_offs),
		.t_palsel(t_palsel),
		.sfile_addr(sfile_addr), .sfile_data(sfile_data), .sfile_we(sfile_we),
		.tsr_rdy(tsr_rdy), .dram_next(dram_next), .dram_rdata(dram_rdata),
		.tsr_go(tsr_go), .tsr_page(tsr_page), .tsr_line(tsr_line),
		.tsr_addr(tsr_addr), .tsr_x(tsr_x), .tsr_xs(tsr_xs), .tsr_xf(tsr_xf),
		.tsr_pal(tsr_pal), .dram_addr(dram_addr), .dram_req(dram_req),
		.busy(busy)
	);

	always #5 clk = ~clk;

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], b};
		return b;
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = (v << 1) | int'(lfsr_bit());
		return v;
	endfunction

	// tilemap content with a zero tile at every 5th entry
	function automatic logic [15:0] tmap_word(input int i);
		logic [15:0] w;
		w = 16'(i * 40503) ^ 16'(i << 7);
		if (i % 5 == 0)
			w[11:0] = 12'd0;
		return w;
	endfunction

	function automatic ts_task_t make_task(input logic [7:0] page, input logic [8:0] ln,
		input logic [5:0] addr, input logic [8:0] x, input logic [2:0] xs,
		input logic xf, input logic [3:0] pal);
		ts_task_t t;
		t.page = page;
		t.line = ln;
		t.addr = addr;
		t.x = x;
		t.xs = xs;
		t.xf = xf;
		t.pal = pal;
		return t;
	endfunction

	task automatic stop_run();
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_task(input string name, input ts_task_t got, input ts_task_t exp);
		if (got !== exp)
		begin
			$display("** Error: %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_addr(input string name, input logic [20:0] got,
		input logic [20:0] exp);
		if (got !== exp)
		begin
			$display("** Error: %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("** Error: %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT)
		begin
			$display("timeout, run still going after %0d cycles", cycles);
			$display("ERRORS FOUND");
			$fatal(1, "timeout");
		end
	end

	// renderer and DRAM models drive on the falling edge
	// outputs are sampled 2 ns after the falling edge
	always @(negedge clk)
	begin
		if (rdy_rand)
			tsr_rdy = lfsr_bit();
		else
			tsr_rdy = 1'b1;
		// a new word only once the gap has run out
		if (dram_req && gap == 0)
		begin
			dram_next = 1'b1;
			dram_rdata = tmap[{dram_addr[12:7], dram_addr[5:0]}];
			got_addr.push_back(dram_addr);
			gap = dram_rand ? rand_bits(2) : 0;
		end
		else
		begin
			dram_next = 1'b0;
			if (dram_req && gap > 0)
				gap = gap - 1;
		end
		#2;
		if (dram_req)
			req_seen = 1'b1;
		if (tsr_go)
		begin
			if (!tsr_rdy)
			begin
				$display("renderer task issued while tsr_rdy was low");
				stop_run();
			end
			got_task.push_back(make_task(tsr_page, tsr_line, tsr_addr, tsr_x,
				tsr_xs, tsr_xf, tsr_pal));
			last_go_cyc = cycles;
		end
		if (busy_q && !busy)
			fall_cyc = cycles;
		busy_q = busy;
	end

	// expected tile tasks and DRAM addresses of one line
	task automatic tile_ref();
		logic [8:0] lt;
		logic [5:0] col;
		logic [15:0] w;
		tile_desc_t d;
		lt = line + ty_offs;
		for (int tx = 0; tx <= int'(num_tiles); tx++)
		begin
			col = 6'(tx + int'(tx_offs[8:3]));
			exp_addr.push_back({tmpage, lt[8:3], 1'b0, col});
			w = tmap[{lt[8:3], col}];
			d = tile_desc_t'(w);
			if (d.tnum != 12'd0)
				exp_task.push_back(make_task(tgpage,
					{d.tnum[11:6], lt[2:0] ^ {3{d.yflip}}}, d.tnum[5:0],
					9'(tx * 8 - int'(tx_offs[2:0])), 3'd0, d.xflip,
					{t_palsel, d.pal}));
		end
	endtask

	// one sprite layer up to a leap or the end of the file
	task automatic sprite_ref(inout int base, output logic ended);
		spr_r0_t r0;
		spr_r1_t r1;
		spr_r2_t r2;
		logic [8:0] sl;
		logic [5:0] ymax;
		logic [5:0] off;
		ended = 1'b1;
		while (base < `TS_SPR_LAST)
		begin
			r0 = spr_r0_t'(smem[base]);
			r1 = spr_r1_t'(smem[base + 1]);
			r2 = spr_r2_t'(smem[base + 2]);
			sl = line - r0.y;
			ymax = {r0.ysz, 3'b111};
			if (r0.act && sl <= 9'(ymax))
			begin
				off = r0.yflip ? 6'(ymax - sl[5:0]) : sl[5:0];
				exp_task.push_back(make_task(sgpage,
					9'({r2.tnum[11:6], 3'b000} + off), r2.tnum[5:0],
					r1.x, r1.xs, r1.xflip, r2.pal));
			end
			base = base + 3;
			if (r0.leap)
			begin
				ended = 1'b0;
				return;
			end
		end
	endtask

	task automatic put_spr(input int n, input logic [8:0] y, input logic [2:0] ysz,
		input logic act, input logic leap, input logic yf, input logic [8:0] x,
		input logic [2:0] xs, input logic xf, input logic [11:0] tnum,
		input logic [3:0] pal);
		spr_r0_t r0;
		spr_r1_t r1;
		spr_r2_t r2;
		r0 = '0;
		r1 = '0;
		r0.y = y;
		r0.ysz = ysz;
		r0.act = act;
		r0.leap = leap;
		r0.yflip = yf;
		r1.x = x;
		r1.xs = xs;
		r1.xflip = xf;
		r2.tnum = tnum;
		r2.pal = pal;
		smem[3 * n] = r0;
		smem[3 * n + 1] = r1;
		smem[3 * n + 2] = r2;
	endtask

	// whole sprite file written while busy is low
	task automatic load_sfile();
		for (int a = 0; a < `TS_SFILE_WORDS; a++)
		begin
			@(negedge clk);
			sfile_we = 1'b1;
			sfile_addr = 8'(a);
			sfile_data = smem[a];
		end
		@(negedge clk);
		sfile_we = 1'b0;
	endtask

	task automatic run_line();
		int base;
		logic ended;
		exp_task.delete();
		exp_addr.delete();
		got_task.delete();
		got_addr.delete();
		req_seen = 1'b0;
		base = 0;
		ended = 1'b1;
		// expected order back to front is S0 then T then S1
		if (spr_en)
			sprite_ref(base, ended);
		if (tile_en)
			tile_ref();
		if (spr_en && !ended)
			sprite_ref(base, ended);
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		#1;
		check_bit("busy", busy, 1'b1);
		while (busy)
			@(negedge clk);
		repeat (2) @(negedge clk);
		if (got_task.size() != exp_task.size())
		begin
			$display("wrong task count, got %0d expected %0d",
				got_task.size(), exp_task.size());
			stop_run();
		end
		foreach (exp_task[i])
			check_task("tsr task", got_task[i], exp_task[i]);
		if (got_addr.size() != exp_addr.size())
		begin
			$display("wrong DRAM word count, got %0d expected %0d",
				got_addr.size(), exp_addr.size());
			stop_run();
		end
		foreach (exp_addr[i])
			check_addr("dram_addr", got_addr[i], exp_addr[i]);
		if (!tile_en && req_seen)
		begin
			$display("dram_req rose with the tile layers disabled");
			stop_run();
		end
		if (got_task.size() > 0 && fall_cyc <= last_go_cyc)
		begin
			$display("busy fell before the last task was issued");
			stop_run();
		end
	endtask

	// tile row with column wrap, scroll and y flip
	// sprite 6 crosses line 37 and must stay hidden with sprites off
	task automatic tile_row();
		spr_en = 1'b0;
		tile_en = 1'b1;
		line = 9'd37;
		ty_offs = 9'd500;
		tx_offs = 9'd485;
		num_tiles = 6'd20;
		run_line();
	endtask

	// sprite visibility with the tiles off
	task automatic sprite_visibility();
		foreach (smem[i])
			smem[i] = 16'h0000;
		put_spr(0, 9'd90, 3'd1, 1'b1, 1'b0, 1'b0, 9'd16, 3'd1, 1'b0, 12'h123, 4'd2);
		put_spr(1, 9'd95, 3'd0, 1'b1, 1'b0, 1'b1, 9'd40, 3'd0, 1'b1, 12'h2c7, 4'd7);
		put_spr(2, 9'd100, 3'd0, 1'b0, 1'b0, 1'b0, 9'd60, 3'd0, 1'b0, 12'h055, 4'd1);
		// one line below so the sprite line wraps
		put_spr(3, 9'd101, 3'd0, 1'b1, 1'b0, 1'b0, 9'd80, 3'd2, 1'b0, 12'h066, 4'd3);
		put_spr(4, 9'd60, 3'd3, 1'b1, 1'b0, 1'b0, 9'd99, 3'd3, 1'b0, 12'h077, 4'd4);
		put_spr(5, 9'd40, 3'd7, 1'b1, 1'b0, 1'b1, 9'd400, 3'd7, 1'b1, 12'hfc1, 4'd15);
		put_spr(6, 9'd30, 3'd0, 1'b1, 1'b0, 1'b0, 9'd120, 3'd0, 1'b0, 12'h0a9, 4'd5);
		load_sfile();
		spr_en = 1'b1;
		tile_en = 1'b0;
		line = 9'd100;
		run_line();
	endtask

	// a visible leap ends S0 and an invisible leap ends S1
	task automatic setup_layers();
		foreach (smem[i])
			smem[i] = 16'h0000;
		put_spr(0, 9'd96, 3'd0, 1'b1, 1'b0, 1'b0, 9'd10, 3'd1, 1'b0, 12'h0c5, 4'd3);
		put_spr(1, 9'd90, 3'd1, 1'b1, 1'b1, 1'b1, 9'd200, 3'd2, 1'b1, 12'h3ff, 4'd9);
		put_spr(2, 9'd100, 3'd0, 1'b1, 1'b0, 1'b0, 9'd300, 3'd0, 1'b0, 12'h041, 4'd5);
		put_spr(3, 9'd20, 3'd0, 1'b1, 1'b1, 1'b0, 9'd5, 3'd0, 1'b0, 12'h011, 4'd6);
		put_spr(4, 9'd99, 3'd0, 1'b1, 1'b0, 1'b0, 9'd7, 3'd0, 1'b0, 12'h022, 4'd8);
		load_sfile();
		spr_en = 1'b1;
		tile_en = 1'b1;
		line = 9'd100;
		ty_offs = 9'd3;
		tx_offs = 9'd19;
		num_tiles = 6'd12;
	endtask

	task automatic layer_order();
		setup_layers();
		rdy_rand = 1'b0;
		dram_rand = 1'b0;
		run_line();
		prev_task = got_task;
	endtask

	task automatic renderer_backpressure();
		rdy_rand = 1'b1;
		run_line();
		foreach (prev_task[i])
			check_task("tsr task under back-pressure", got_task[i], prev_task[i]);
	endtask

	// stalls plus a second line to see busy rise again
	task automatic dram_stall_lines();
		dram_rand = 1'b1;
		rdy_rand = 1'b1;
		run_line();
		run_line();
	endtask

	initial
	begin
		rst = 1'b1;
		start = 1'b0;
		line = '0;
		spr_en = 1'b0;
		tile_en = 1'b0;
		tgpage = 8'h21;
		sgpage = 8'h64;
		tmpage = 8'h5a;
		num_tiles = '0;
		tx_offs = '0;
		ty_offs = '0;
		t_palsel = 2'b10;
		sfile_addr = '0;
		sfile_data = '0;
		sfile_we = 1'b0;
		tsr_rdy = 1'b0;
		dram_next = 1'b0;
		dram_rdata = '0;
		for (int i = 0; i < 4096; i++)
			tmap[i] = tmap_word(i);
		repeat (10) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		#1;
		check_bit("busy", busy, 1'b0);
		check_bit("dram_req", dram_req, 1'b0);
		check_bit("tsr_go", tsr_go, 1'b0);
		// sprite file stays loaded for the tile row
		sprite_visibility();
		tile_row();
		layer_order();
		renderer_backpressure();
		dram_stall_lines();
		$display("NO ERRORS");
		$finish;
	end
endmodule

`default_nettype wire

// File: src.f
+incdir+rtl
rtl/ts_desc_pkg.sv
rtl/ts_seq_pkg.sv
rtl/ts_task_if.sv
rtl/ts_dpram.sv
rtl/ts_tile_scan.sv
rtl/ts_sprite_scan.sv
rtl/ts_layer_seq.sv
rtl/video_ts.sv
verif/tb_video_ts.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench; exit status is the simulation result
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal \
	-f src.f \
	--top-module tb_video_ts \
	--Mdir obj_dir \
	-o tb_video_ts
./obj_dir/tb_video_ts
